// ==== verilog/extBusPkg.sv ====
`default_nettype none

// Word layout and sizing of the external bus register file
package extBusPkg;

    // Geometry of the register file
    localparam int WORD_COUNT = 4;              // Words held by every slice

    // Field and slice widths
    typedef logic [3:0]                         nibbleT;   // One slice data lane
    typedef logic [$clog2(WORD_COUNT)-1:0]      addrT;     // Word address
    typedef logic [63:0]                        dataT;     // Data field
    typedef logic [7:0]                         tagT;      // Tag field

    // Tag sits above the data field
    typedef logic [$bits(tagT)+$bits(dataT)-1:0] wordT;

    localparam int SLICE_COUNT = $bits(wordT) / $bits(nibbleT);   // 18 slices
    localparam int DATA_SLICES = $bits(dataT) / $bits(nibbleT);   // Slices 16, 17 hold the tag

endpackage

`default_nettype wire

// ==== verilog/portPkg.sv ====
`default_nettype none

// Request and response bundles for the processor ports and the X channels
package portPkg;

    localparam int CHAN_COUNT = 2;              // Peer I/O channels sharing port X

    typedef logic [$clog2(CHAN_COUNT)-1:0] chanIdT;   // Channel number

    // Processor side request, acts in the cycle it is presented
    typedef struct packed {
        logic            en;                    // Port active this cycle
        logic            we;                    // Write when set, else read
        extBusPkg::addrT addr;
        extBusPkg::wordT wdata;
    } portReqT;

    // Channel request, qualified by chanValid
    typedef struct packed {
        logic            we;
        extBusPkg::addrT addr;
        extBusPkg::wordT wdata;
    } xReqT;

    // Read response, one cycle after the accepted request
    typedef struct packed {
        chanIdT          chan;                  // Requesting channel
        extBusPkg::wordT rdata;
    } xRspT;

endpackage

`default_nettype wire

// ==== verilog/k1802Slice.sv ====
`default_nettype none
`timescale 1ns/1ns

// Four-port, four-word, 4-bit memory slice modelled on the K1802 part
module k1802Slice (
    input  wire                    clk,

    input  wire                    aEn,       // A port, highest write priority
    input  wire                    aWe,
    input  wire extBusPkg::addrT   aAddr,
    input  wire extBusPkg::nibbleT aWdata,
    output extBusPkg::nibbleT      aRdata,

    input  wire                    bEn,       // B port
    input  wire                    bWe,
    input  wire extBusPkg::addrT   bAddr,
    input  wire extBusPkg::nibbleT bWdata,
    output extBusPkg::nibbleT      bRdata,

    input  wire                    cEn,       // C port
    input  wire                    cWe,
    input  wire extBusPkg::addrT   cAddr,
    input  wire extBusPkg::nibbleT cWdata,
    output extBusPkg::nibbleT      cRdata,

    input  wire                    xEn,       // X port, lowest write priority
    input  wire                    xWe,
    input  wire extBusPkg::addrT   xAddr,
    input  wire extBusPkg::nibbleT xWdata,
    output extBusPkg::nibbleT      xRdata
);
    import extBusPkg::*;

    nibbleT     mem   [WORD_COUNT];           // Stored nibbles
    logic [3:0] en;                           // Index 0 is A, index 3 is X
    logic [3:0] we;
    addrT       addr  [4];
    nibbleT     wdata [4];
    nibbleT     rdata [4];                    // Read registers per port

    assign en    = {xEn, cEn, bEn, aEn};
    assign we    = {xWe, cWe, bWe, aWe};
    assign addr  = '{aAddr, bAddr, cAddr, xAddr};
    assign wdata = '{aWdata, bWdata, cWdata, xWdata};

    always_ff @(posedge clk) begin
        // Lowest priority first, so the A write lands last
        for (int p = 3; p >= 0; p--) begin
            if (en[p] && we[p]) begin
                mem[addr[p]] <= wdata[p];
            end
        end

        // Reads see the value from before this edge
        for (int p = 0; p < 4; p++) begin
            rdata[p] <= (en[p] && !we[p]) ? mem[addr[p]] : '0;
        end
    end

    assign aRdata = rdata[0];
    assign bRdata = rdata[1];
    assign cRdata = rdata[2];
    assign xRdata = rdata[3];

    // A write strobe on a disabled port means the driving logic lost its enable
    assert property (@(posedge clk) (we & ~en) == 4'b0000)
        else $error("Slice write strobe without port enable");

endmodule

`default_nettype wire

// ==== verilog/extBusRegFile.sv ====
`default_nettype none
`timescale 1ns/1ns

// 72-bit four-port register file, eighteen slices side by side
module extBusRegFile (
    input  wire                    clk,
    input  wire                    rst,

    input  wire portPkg::portReqT  aReq,
    input  wire portPkg::portReqT  bReq,
    input  wire                    bTagEn,     // B reaches the tag slices only when set
    input  wire portPkg::portReqT  cReq,

    input  wire                    xEn,
    input  wire                    xWe,
    input  wire extBusPkg::addrT   xAddr,
    input  wire extBusPkg::wordT   xWdata,

    output extBusPkg::wordT        aRdata,
    output extBusPkg::wordT        bRdata,
    output extBusPkg::wordT        cRdata,
    output extBusPkg::wordT        xRdata
);
    import extBusPkg::*;
    import portPkg::*;

    // Hold a port idle while in reset
    function automatic portReqT holdReq(input portReqT req, input logic hold);
        portReqT held;
        held    = req;
        held.en = req.en & ~hold;
        held.we = req.we & ~hold;
        return held;
    endfunction

    portReqT aGate;
    portReqT bGate;
    portReqT cGate;
    logic    xEnGate;
    logic    xWeGate;
    logic    bTagSliceEn;                       // B enable seen by the tag slices
    logic    bTagSliceWe;

    assign aGate = holdReq(aReq, rst);
    assign bGate = holdReq(bReq, rst);
    assign cGate = holdReq(cReq, rst);

    assign xEnGate = xEn & ~rst;
    assign xWeGate = xWe & ~rst;

    // Tag untouched on writes, read back as zero
    assign bTagSliceEn = bGate.en & bTagEn;
    assign bTagSliceWe = bGate.we & bTagEn;

    for (genvar s = 0; s < SLICE_COUNT; s++) begin : gSlice
        k1802Slice uSlice (
            .clk    (clk),

            .aEn    (aGate.en),
            .aWe    (aGate.we),
            .aAddr  (aGate.addr),
            .aWdata (aGate.wdata[s*$bits(nibbleT) +: $bits(nibbleT)]),
            .aRdata (aRdata[s*$bits(nibbleT) +: $bits(nibbleT)]),

            .bEn    ((s < DATA_SLICES) ? bGate.en : bTagSliceEn),
            .bWe    ((s < DATA_SLICES) ? bGate.we : bTagSliceWe),
            .bAddr  (bGate.addr),
            .bWdata (bGate.wdata[s*$bits(nibbleT) +: $bits(nibbleT)]),
            .bRdata (bRdata[s*$bits(nibbleT) +: $bits(nibbleT)]),

            .cEn    (cGate.en),
            .cWe    (cGate.we),
            .cAddr  (cGate.addr),
            .cWdata (cGate.wdata[s*$bits(nibbleT) +: $bits(nibbleT)]),
            .cRdata (cRdata[s*$bits(nibbleT) +: $bits(nibbleT)]),

            .xEn    (xEnGate),
            .xWe    (xWeGate),
            .xAddr  (xAddr),
            .xWdata (xWdata[s*$bits(nibbleT) +: $bits(nibbleT)]),
            .xRdata (xRdata[s*$bits(nibbleT) +: $bits(nibbleT)])
        );
    end

    // X strobes come from the channel arbiter and must carry its enable
    assert property (@(posedge clk) disable iff (rst) xWe |-> xEn)
        else $error("X port write while X port disabled");

endmodule

`default_nettype wire

// ==== verilog/xPortArbiter.sv ====
`default_nettype none
`timescale 1ns/1ns

// Round-robin sharing of register file port X between the I/O channels
module xPortArbiter (
    input  wire                                          clk,
    input  wire                                          rst,

    input  wire [portPkg::CHAN_COUNT-1:0]                chanValid,
    input  wire portPkg::xReqT [portPkg::CHAN_COUNT-1:0] chanReq,
    output logic [portPkg::CHAN_COUNT-1:0]               chanReady,

    output logic                                         xEn,
    output logic                                         xWe,
    output extBusPkg::addrT                              xAddr,
    output extBusPkg::wordT                              xWdata,
    input  wire extBusPkg::wordT                         xRdata,

    output logic                                         rspValid,
    output portPkg::xRspT                                rsp
);
    import portPkg::*;

    chanIdT lastGrant;                          // Channel granted most recently
    chanIdT prio;                               // Channel favoured this cycle
    chanIdT grantId;
    logic   anyValid;
    xReqT   granted;
    logic   rdPending;                          // Read accepted on the last edge
    chanIdT rdChan;                             // Its channel

    always_comb begin
        prio     = lastGrant + 1'b1;
        // With two channels the fallback is simply the other one
        grantId  = chanValid[prio] ? prio : chanIdT'(prio + 1'b1);
        anyValid = |chanValid;
        granted  = chanReq[grantId];

        chanReady          = '0;
        chanReady[grantId] = anyValid;
    end

    // Accepted request goes to port X in the same cycle
    assign xEn    = anyValid;
    assign xWe    = anyValid & granted.we;
    assign xAddr  = granted.addr;
    assign xWdata = granted.wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            lastGrant <= chanIdT'(CHAN_COUNT - 1);   // Channel 0 goes first
            rdPending <= 1'b0;
            rdChan    <= '0;
        end else begin
            if (anyValid) begin
                lastGrant <= grantId;
            end
            rdPending <= anyValid & ~granted.we;      // Writes get no response
            rdChan    <= grantId;
        end
    end

    // Slice read registers deliver the data one edge after acceptance
    assign rspValid = rdPending;
    assign rsp      = '{chan: rdChan, rdata: xRdata};

    assert property (@(posedge clk) disable iff (rst) $onehot0(chanReady))
        else $error("More than one channel granted");

    assert property (@(posedge clk) disable iff (rst) (chanReady & ~chanValid) == '0)
        else $error("Ready raised for a channel without valid");

endmodule

`default_nettype wire

// ==== verilog/extBusTop.sv ====
`default_nettype none
`timescale 1ns/1ns

// External bus top, processor ports direct and port X behind the arbiter
module extBusTop (
    input  wire                                          clk,
    input  wire                                          rst,

    input  wire portPkg::portReqT                        aReq,
    input  wire portPkg::portReqT                        bReq,
    input  wire                                          bTagEn,
    input  wire portPkg::portReqT                        cReq,

    input  wire [portPkg::CHAN_COUNT-1:0]                chanValid,
    input  wire portPkg::xReqT [portPkg::CHAN_COUNT-1:0] chanReq,
    output logic [portPkg::CHAN_COUNT-1:0]               chanReady,
    output logic                                         rspValid,
    output portPkg::xRspT                                rsp,

    output extBusPkg::wordT                              aRdata,
    output extBusPkg::wordT                              bRdata,
    output extBusPkg::wordT                              cRdata
);
    import extBusPkg::*;

    logic xEn;                                  // Arbiter to register file X port
    logic xWe;
    addrT xAddr;
    wordT xWdata;
    wordT xRdata;

    xPortArbiter uArbiter (
        .clk       (clk),
        .rst       (rst),
        .chanValid (chanValid),
        .chanReq   (chanReq),
        .chanReady (chanReady),
        .xEn       (xEn),
        .xWe       (xWe),
        .xAddr     (xAddr),
        .xWdata    (xWdata),
        .xRdata    (xRdata),
        .rspValid  (rspValid),
        .rsp       (rsp)
    );

    extBusRegFile uRegFile (
        .clk    (clk),
        .rst    (rst),
        .aReq   (aReq),
        .bReq   (bReq),
        .bTagEn (bTagEn),
        .cReq   (cReq),
        .xEn    (xEn),
        .xWe    (xWe),
        .xAddr  (xAddr),
        .xWdata (xWdata),
        .aRdata (aRdata),
        .bRdata (bRdata),
        .cRdata (cRdata),
        .xRdata (xRdata)
    );

endmodule

`default_nettype wire

// ==== verification/extBusTb.sv ====
`default_nettype none
`timescale 1ns/1ns

module extBusTb;
    import extBusPkg::*;
    import portPkg::*;

    // One table row: processor port requests plus new channel requests
    typedef struct packed {
        portReqT                a;
        portReqT                b;
        portReqT                c;
        logic                   tagEn;
        logic [CHAN_COUNT-1:0]  chanOn;         // Channel adds a request this step
        xReqT [CHAN_COUNT-1:0]  chan;
    } stepT;

    logic                       clk;
    logic                       rst;
    portReqT                    aReq;
    portReqT                    bReq;
    portReqT                    cReq;
    logic                       bTagEn;
    logic [CHAN_COUNT-1:0]      chanValid;
    xReqT [CHAN_COUNT-1:0]      chanReq;
    logic [CHAN_COUNT-1:0]      chanReady;
    logic                       rspValid;
    xRspT                       rsp;
    wordT                       aRdata;
    wordT                       bRdata;
    wordT                       cRdata;

    stepT       steps [$];
    xReqT       chanQ0 [$];                     // Requests waiting on channel 0
    xReqT       chanQ1 [$];
    logic [31:0] lfsrState;
    int         checkCount;
    int         errorCount;
    int         cycleCount;
    int         cycleLimit;
    int         stepIdx;

    // Reference model state
    wordT       model [WORD_COUNT];
    chanIdT     lastGrantM;
    wordT       expA;
    wordT       expB;
    wordT       expC;
    logic       expRspValid;
    xRspT       expRsp;
    logic [CHAN_COUNT-1:0] expReady;

    extBusTop UUT (
        .clk       (clk),
        .rst       (rst),
        .aReq      (aReq),
        .bReq      (bReq),
        .bTagEn    (bTagEn),
        .cReq      (cReq),
        .chanValid (chanValid),
        .chanReq   (chanReq),
        .chanReady (chanReady),
        .rspValid  (rspValid),
        .rsp       (rsp),
        .aRdata    (aRdata),
        .bRdata    (bRdata),
        .cRdata    (cRdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsrBit();
        logic fb;
        fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic wordT randWord();
        wordT w;
        for (int i = 0; i < $bits(wordT); i++) begin
            w[i] = lfsrBit();
        end
        return w;
    endfunction

    function automatic portReqT portWr(input addrT addr);
        return '{en: 1'b1, we: 1'b1, addr: addr, wdata: randWord()};
    endfunction

    function automatic portReqT portRd(input addrT addr);
        return '{en: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    endfunction

    function automatic portReqT portIdle();
        return '0;
    endfunction

    function automatic xReqT chanWr(input addrT addr);
        return '{we: 1'b1, addr: addr, wdata: randWord()};
    endfunction

    function automatic xReqT chanRd(input addrT addr);
        return '{we: 1'b0, addr: addr, wdata: '0};
    endfunction

    function automatic xReqT chanIdle();
        return '0;
    endfunction

    task automatic addStep(input portReqT a, input portReqT b, input portReqT c,
                           input logic tagEn, input logic [CHAN_COUNT-1:0] on,
                           input xReqT ch0, input xReqT ch1);
        stepT s;
        s.a       = a;
        s.b       = b;
        s.c       = c;
        s.tagEn   = tagEn;
        s.chanOn  = on;
        s.chan[0] = ch0;
        s.chan[1] = ch1;
        steps.push_back(s);
    endtask

    // Outputs now on the bus belong to the inputs of the previous cycle
    task automatic checkOutputs();
        checkCount += 4;
        if (aRdata !== expA) begin
            errorCount++;
            $display("** Error [%0t] port A read: got %h, expected %h", $time, aRdata, expA);
        end
        if (bRdata !== expB) begin
            errorCount++;
            $display("** Error [%0t] port B read: got %h, expected %h", $time, bRdata, expB);
        end
        if (cRdata !== expC) begin
            errorCount++;
            $display("** Error [%0t] port C read: got %h, expected %h", $time, cRdata, expC);
        end
        if (rspValid !== expRspValid) begin
            errorCount++;
            $display("** Error [%0t] rspValid: got %b, expected %b", $time, rspValid,
                     expRspValid);
        end
        if (expRspValid) begin
            checkCount++;
            if (rsp !== expRsp) begin
                errorCount++;
                $display("** Error [%0t] response: got chan %0d data %h, expected chan %0d data %h",
                         $time, rsp.chan, rsp.rdata, expRsp.chan, expRsp.rdata);
            end
        end
    endtask

    task automatic predictCycle();
        logic   any;
        chanIdT favour;
        chanIdT g;
        xReqT   xr;
        any    = |chanValid;
        favour = (lastGrantM == 1'b0) ? 1'b1 : 1'b0;   // Channel not granted last
        g      = chanValid[favour] ? favour : ~favour;
        xr     = chanReq[g];

        expReady = any ? (2'b01 << g) : 2'b00;
        checkCount++;
        if (chanReady !== expReady) begin
            errorCount++;
            $display("** Error [%0t] chanReady: got %b, expected %b", $time, chanReady, expReady);
        end

        // Reads see the words from before this edge
        expA = (aReq.en && !aReq.we) ? model[aReq.addr] : '0;
        expB = (bReq.en && !bReq.we) ? model[bReq.addr] : '0;
        if (!bTagEn) begin
            expB = wordT'(dataT'(expB));        // Tag reads as zero
        end
        expC        = (cReq.en && !cReq.we) ? model[cReq.addr] : '0;
        expRspValid = any && !xr.we;
        expRsp      = '{chan: g, rdata: expRspValid ? model[xr.addr] : '0};

        // Lowest priority first so A ends up on top
        if (any && xr.we) begin
            model[xr.addr] = xr.wdata;
        end
        if (cReq.en && cReq.we) begin
            model[cReq.addr] = cReq.wdata;
        end
        if (bReq.en && bReq.we) begin
            if (bTagEn) begin
                model[bReq.addr] = bReq.wdata;
            end else begin
                model[bReq.addr] = {tagT'(model[bReq.addr] >> $bits(dataT)), dataT'(bReq.wdata)};
            end
        end
        if (aReq.en && aReq.we) begin
            model[aReq.addr] = aReq.wdata;
        end
        if (any) begin
            lastGrantM = g;
        end
    endtask

    task automatic runCycle(input stepT s);
        @(posedge clk);
        aReq   <= s.a;
        bReq   <= s.b;
        cReq   <= s.c;
        bTagEn <= s.tagEn;
        if (s.chanOn[0]) begin
            chanQ0.push_back(s.chan[0]);
        end
        if (s.chanOn[1]) begin
            chanQ1.push_back(s.chan[1]);
        end
        // Head of each queue stays on the bus until it is accepted
        chanValid  <= {chanQ1.size() != 0, chanQ0.size() != 0};
        chanReq[0] <= (chanQ0.size() != 0) ? chanQ0[0] : '0;
        chanReq[1] <= (chanQ1.size() != 0) ? chanQ1[0] : '0;

        @(negedge clk);
        checkOutputs();
        predictCycle();
        if (chanValid[0] && chanReady[0]) begin
            void'(chanQ0.pop_front());      // Transfer on the coming edge
        end
        if (chanValid[1] && chanReady[1]) begin
            void'(chanQ1.pop_front());
        end
    endtask

    initial begin
        rst         = 1'b1;
        aReq        = '0;
        bReq        = '0;
        cReq        = '0;
        bTagEn      = 1'b0;
        chanValid   = '0;
        chanReq     = '0;
        lfsrState   = 32'hcf94_f728;
        checkCount  = 0;
        errorCount  = 0;
        cycleCount  = 0;
        lastGrantM  = 1'b1;                     // Channel 0 favoured after reset
        expA        = '0;
        expB        = '0;
        expC        = '0;
        expRspValid = 1'b0;
        expRsp      = '0;

        // Fill all words, then read back on B, C and X
        addStep(portWr(2'd0), portWr(2'd1), portWr(2'd2), 1'b1, 2'b01, chanWr(2'd3), chanIdle());
        addStep(portWr(2'd0), portIdle(), portIdle(), 1'b1, 2'b00, chanIdle(), chanIdle());
        addStep(portRd(2'd3), portRd(2'd0), portRd(2'd0), 1'b1, 2'b10, chanIdle(), chanRd(2'd0));
        // B without tag enable
        addStep(portIdle(), portWr(2'd1), portIdle(), 1'b0, 2'b00, chanIdle(), chanIdle());
        addStep(portRd(2'd1), portRd(2'd1), portRd(2'd1), 1'b0, 2'b00, chanIdle(), chanIdle());
        addStep(portIdle(), portRd(2'd1), portIdle(), 1'b1, 2'b01, chanRd(2'd1), chanIdle());
        // Same-address collisions
        addStep(portRd(2'd2), portWr(2'd2), portWr(2'd2), 1'b1, 2'b01, chanWr(2'd2), chanIdle());
        addStep(portWr(2'd3), portWr(2'd3), portWr(2'd3), 1'b1, 2'b10, chanIdle(), chanRd(2'd3));
        addStep(portIdle(), portRd(2'd0), portWr(2'd0), 1'b1, 2'b10, chanIdle(), chanWr(2'd0));
        addStep(portRd(2'd2), portRd(2'd3), portRd(2'd0), 1'b1, 2'b01, chanWr(2'd1), chanIdle());
        addStep(portRd(2'd1), portIdle(), portIdle(), 1'b1, 2'b00, chanIdle(), chanIdle());
        // Single channel, then a held request
        addStep(portIdle(), portIdle(), portIdle(), 1'b1, 2'b10, chanIdle(), chanWr(2'd2));
        addStep(portIdle(), portIdle(), portRd(2'd2), 1'b1, 2'b10, chanIdle(), chanRd(2'd2));
        addStep(portIdle(), portIdle(), portIdle(), 1'b1, 2'b10, chanIdle(), chanRd(2'd1));
        addStep(portIdle(), portIdle(), portIdle(), 1'b1, 2'b10, chanIdle(), chanWr(2'd0));
        addStep(portIdle(), portIdle(), portIdle(), 1'b1, 2'b11, chanRd(2'd0), chanRd(2'd2));
        addStep(portIdle(), portIdle(), portIdle(), 1'b1, 2'b01, chanRd(2'd1), chanIdle());
        addStep(portIdle(), portIdle(), portIdle(), 1'b1, 2'b00, chanIdle(), chanIdle());
        // Both channels busy, queues back up
        addStep(portRd(2'd0), portIdle(), portIdle(), 1'b1, 2'b11, chanWr(2'd0), chanRd(2'd0));
        addStep(portIdle(), portIdle(), portIdle(), 1'b1, 2'b11, chanRd(2'd0), chanRd(2'd1));
        addStep(portIdle(), portIdle(), portRd(2'd2), 1'b1, 2'b11, chanWr(2'd1), chanRd(2'd3));
        addStep(portIdle(), portIdle(), portIdle(), 1'b1, 2'b11, chanRd(2'd1), chanWr(2'd3));
        addStep(portIdle(), portRd(2'd3), portIdle(), 1'b0, 2'b11, chanRd(2'd3), chanRd(2'd2));
        addStep(portIdle(), portIdle(), portIdle(), 1'b1, 2'b11, chanRd(2'd2), chanRd(2'd0));
        addStep(portRd(2'd1), portIdle(), portRd(2'd3), 1'b1, 2'b00, chanIdle(), chanIdle());

        cycleLimit = steps.size() * 4 + 50;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        stepIdx = 0;
        while (stepIdx < steps.size() || chanQ0.size() != 0 || chanQ1.size() != 0) begin
            if (stepIdx < steps.size()) begin
                runCycle(steps[stepIdx]);
                stepIdx++;
            end else begin
                runCycle('0);                   // Drain queued channel requests
            end
        end
        runCycle('0);                           // Collect the last responses

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== extbus.f ====
verilog/extBusPkg.sv
verilog/portPkg.sv
verilog/k1802Slice.sv
verilog/extBusRegFile.sv
verilog/xPortArbiter.sv
verilog/extBusTop.sv
verification/extBusTb.sv
